/* Makefile */
TOP = tb_lab_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f filelist.f -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir

/* filelist.f */
src/lab_pkg.sv
src/lfsr_gen.sv
src/barrel_shifter.sv
src/alu4.sv
src/hex_seg.sv
src/result_display.sv
src/lab_top.sv
sim/lab_top_chk.sv
sim/tb_lab_top.sv

/* sim/lab_top_chk.sv */
`timescale 1ns/1ps

module lab_top_chk #(
    parameter lab_pkg::byte_t SEED = 8'h01
) (
    input logic           btn,
    input logic           reset,
    input logic           step,
    input lab_pkg::byte_t value
);

    // seed loaded on the edge with reset high
    a_seed_after_reset: assert property (@(posedge btn) reset |=> value == SEED)
        else $error("generator value differs from the seed after reset");

    a_hold_without_step: assert property (@(posedge btn) (!reset && !step) |=> $stable(value))
        else $error("generator value changed with step low");

    // zero never sticks
    a_zero_escape: assert property (
        @(posedge btn) (!reset && step && value == 8'h00) |=> value == 8'h01
    ) else $error("generator did not leave the zero state");

endmodule

bind lfsr_gen lab_top_chk #(
    .SEED (SEED)
) u_chk (
    .btn   (btn),
    .reset (reset),
    .step  (step),
    .value (value)
);

/* sim/tb_lab_top.sv */
`timescale 1ns/1ps

module tb_lab_top;

    localparam int EDGE_TIMEOUT = 100;
    localparam int MAX_ROWS = 128;

    logic        btn;
    logic        reset;
    logic [15:0] sw;
    logic [15:0] ledr;
    logic [7:0]  seg0;
    logic [7:0]  seg1;
    logic [7:0]  seg2;
    logic [7:0]  seg3;

    // rows hold mode, switches below the mode field, edge count and expected bytes
    logic [1:0]     tbl_mode [0:MAX_ROWS-1];
    logic [13:0]    tbl_sw [0:MAX_ROWS-1];
    int             tbl_edges [0:MAX_ROWS-1];
    lab_pkg::byte_t tbl_exp [0:MAX_ROWS-1];
    lab_pkg::byte_t tbl_zero [0:MAX_ROWS-1];
    int             n_rows;

    lab_pkg::byte_t lfsr_model;
    lab_pkg::byte_t zero_model;
    lab_pkg::byte_t zero_val;
    int             seed;
    int             edge_count = 0;
    int             errors;
    int             checks;
    logic           timed_out;

    lab_top #(
        .SEED (8'h5A)
    ) dut0 (
        .btn   (btn),
        .reset (reset),
        .sw    (sw),
        .ledr  (ledr),
        .seg0  (seg0),
        .seg1  (seg1),
        .seg2  (seg2),
        .seg3  (seg3)
    );

    // second generator that starts in the all-zero state
    lfsr_gen #(
        .SEED (8'h00)
    ) zero_gen (
        .btn   (btn),
        .reset (reset),
        .step  (sw[13]),
        .value (zero_val)
    );

    initial btn = 1'b0;
    always #20 btn = ~btn;

    always @(posedge btn) begin
        edge_count <= edge_count + 1;
    end

    function automatic lab_pkg::byte_t lfsr_step(lab_pkg::byte_t v);
        logic fb;
        fb = v[4] ^ v[3] ^ v[2] ^ v[0];
        if (v == 8'h00) return 8'h01;
        return {fb, v[7:1]};
    endfunction

    function automatic lab_pkg::byte_t shift_model(lab_pkg::byte_t d, logic [2:0] n,
                                                   logic left, logic arith);
        if (left) return d << n;
        if (arith) return lab_pkg::byte_t'($signed(d) >>> n);
        return d >> n;
    endfunction

    // {carry, ovfl, zero, res}
    function automatic logic [6:0] alu_model(logic [2:0] op, lab_pkg::nib_t a, lab_pkg::nib_t b);
        int         ua;
        int         ub;
        int         sa;
        int         sb;
        int         full;
        logic [3:0] res;
        logic       c;
        logic       v;
        ua = int'(a);
        ub = int'(b);
        sa = a[3] ? ua - 16 : ua;
        sb = b[3] ? ub - 16 : ub;
        full = 0;
        res = 4'h0;
        c = 1'b0;
        v = 1'b0;
        case (op)
            lab_pkg::OP_ADD: begin
                full = ua + ub;
                v = (sa + sb > 7) || (sa + sb < -8);
            end
            lab_pkg::OP_SUB: begin
                full = ua + (15 - ub) + 1;
                v = (sa - sb > 7) || (sa - sb < -8);
            end
            lab_pkg::OP_NOT: res = ~a;
            lab_pkg::OP_AND: res = a & b;
            lab_pkg::OP_OR:  res = a | b;
            lab_pkg::OP_XOR: res = a ^ b;
            lab_pkg::OP_SLT: res = (sa < sb) ? 4'h1 : 4'h0;
            default:         res = (a == b) ? 4'h1 : 4'h0;
        endcase
        if (op == lab_pkg::OP_ADD || op == lab_pkg::OP_SUB) begin
            res = full[3:0];
            c = (full > 15);
        end
        return {c, v, (res == 4'h0), res};
    endfunction

    // lit segments in gfedcba order and inverted for the active-low board
    function automatic logic [7:0] hex_pattern(lab_pkg::nib_t n);
        logic [6:0] lit;
        lit = 7'h00;
        case (n)
            4'h0: lit = 7'h3F;
            4'h1: lit = 7'h06;
            4'h2: lit = 7'h5B;
            4'h3: lit = 7'h4F;
            4'h4: lit = 7'h66;
            4'h5: lit = 7'h6D;
            4'h6: lit = 7'h7D;
            4'h7: lit = 7'h07;
            4'h8: lit = 7'h7F;
            4'h9: lit = 7'h6F;
            4'hA: lit = 7'h77;
            4'hB: lit = 7'h7C;
            4'hC: lit = 7'h39;
            4'hD: lit = 7'h5E;
            4'hE: lit = 7'h79;
            4'hF: lit = 7'h71;
        endcase
        return ~{1'b0, lit};
    endfunction

    function automatic lab_pkg::byte_t expected_byte(logic [1:0] mode, logic [13:0] s,
                                                     lab_pkg::byte_t rnd);
        case (mode)
            lab_pkg::MODE_RAND:  return rnd;
            lab_pkg::MODE_SHIFT: return shift_model(s[7:0], s[10:8], s[11], s[12]);
            lab_pkg::MODE_ALU:   return {1'b0, alu_model(s[10:8], s[3:0], s[7:4])};
            default:             return 8'h00;
        endcase
    endfunction

    task automatic add_row(input logic [1:0] mode, input logic [13:0] s, input int edges);
        for (int e = 0; e < edges; e++) begin
            if (s[13]) begin
                lfsr_model = lfsr_step(lfsr_model);
                zero_model = lfsr_step(zero_model);
            end
        end
        tbl_mode[n_rows] = mode;
        tbl_sw[n_rows] = s;
        tbl_edges[n_rows] = edges;
        tbl_exp[n_rows] = expected_byte(mode, s, lfsr_model);
        tbl_zero[n_rows] = zero_model;
        n_rows++;
    endtask

    task automatic alu_row(input logic [2:0] op, input lab_pkg::nib_t a, input lab_pkg::nib_t b);
        add_row(lab_pkg::MODE_ALU, {3'b000, op, b, a}, 1);
    endtask

    task automatic build_table();
        logic [31:0]    r;
        lab_pkg::byte_t data;
        logic           left;
        logic           arith;
        lfsr_model = 8'h5A;
        zero_model = 8'h00;
        n_rows = 0;
        add_row(lab_pkg::MODE_RAND, 14'h0000, 1);
        for (int k = 0; k < 40; k++) begin
            add_row(lab_pkg::MODE_RAND, 14'h2000, 1);
            if (k % 10 == 9) add_row(lab_pkg::MODE_RAND, 14'h0000, 1);
        end
        // left, logical right, arithmetic right in turn
        for (int k = 0; k < 20; k++) begin
            r = $random(seed);
            data = r[7:0];
            left = (k % 3 == 0);
            arith = (k % 3 == 2);
            if (arith && k % 2 == 0) data[7] = 1'b1;
            add_row(lab_pkg::MODE_SHIFT, {1'b0, arith, left, r[10:8], data}, 1);
        end
        alu_row(lab_pkg::OP_ADD, 4'h9, 4'h8);
        alu_row(lab_pkg::OP_ADD, 4'h7, 4'h1);
        alu_row(lab_pkg::OP_ADD, 4'h3, 4'h4);
        alu_row(lab_pkg::OP_ADD, 4'h8, 4'h8);
        alu_row(lab_pkg::OP_SUB, 4'h5, 4'h5);
        alu_row(lab_pkg::OP_SUB, 4'h2, 4'h5);
        alu_row(lab_pkg::OP_SUB, 4'h8, 4'h1);
        alu_row(lab_pkg::OP_SUB, 4'h7, 4'hF);
        alu_row(lab_pkg::OP_NOT, 4'hA, 4'h0);
        alu_row(lab_pkg::OP_NOT, 4'hF, 4'h3);
        alu_row(lab_pkg::OP_AND, 4'hC, 4'hA);
        alu_row(lab_pkg::OP_OR,  4'h5, 4'hA);
        alu_row(lab_pkg::OP_XOR, 4'hF, 4'hF);
        alu_row(lab_pkg::OP_SLT, 4'hF, 4'h1);
        alu_row(lab_pkg::OP_SLT, 4'h3, 4'h2);
        alu_row(lab_pkg::OP_SLT, 4'h8, 4'h7);
        alu_row(lab_pkg::OP_EQ,  4'h6, 4'h6);
        alu_row(lab_pkg::OP_EQ,  4'h6, 4'h7);
        for (int k = 0; k < 16; k++) begin
            r = $random(seed);
            alu_row(r[2:0], r[7:4], r[11:8]);
        end
        // generator keeps running while dark
        for (int k = 0; k < 6; k++) begin
            add_row(lab_pkg::MODE_OFF, 14'h2000, 1);
        end
        add_row(lab_pkg::MODE_RAND, 14'h0000, 1);
    endtask

    // returns 2 ns after the last edge
    task automatic wait_edges(input int n);
        int target;
        int waited;
        target = edge_count + n;
        waited = 0;
        while (edge_count < target && waited < n * EDGE_TIMEOUT) begin
            #1;
            waited++;
        end
        if (edge_count < target) begin
            timed_out = 1'b1;
            $display("timeout: button edge did not arrive within %0d ns", n * EDGE_TIMEOUT);
        end
        #1;
    endtask

    task automatic compare_val(input string what, input int row,
                               input logic [15:0] got, input logic [15:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0d ns: row %0d %s is %h, expected %h",
                     $time, row, what, got, exp);
        end
    endtask

    task automatic check_row(input int i);
        logic [7:0] p0;
        logic [7:0] p1;
        logic [7:0] p2;
        p0 = lab_pkg::SEG_BLANK;
        p1 = lab_pkg::SEG_BLANK;
        p2 = lab_pkg::SEG_BLANK;
        if (tbl_mode[i] != lab_pkg::MODE_OFF) begin
            p0 = hex_pattern(tbl_exp[i][3:0]);
            p1 = hex_pattern(tbl_exp[i][7:4]);
            p2 = hex_pattern({2'b00, tbl_mode[i]});
        end
        compare_val("ledr", i, ledr, {8'h00, tbl_exp[i]});
        compare_val("seg0", i, {8'h00, seg0}, {8'h00, p0});
        compare_val("seg1", i, {8'h00, seg1}, {8'h00, p1});
        compare_val("seg2", i, {8'h00, seg2}, {8'h00, p2});
        compare_val("seg3", i, {8'h00, seg3}, {8'h00, lab_pkg::SEG_BLANK});
        compare_val("zero seed value", i, {8'h00, zero_val}, {8'h00, tbl_zero[i]});
    endtask

    initial begin
        reset = 1'b1;
        sw = 16'h0000;
        seed = 2;
        errors = 0;
        checks = 0;
        timed_out = 1'b0;
        build_table();
        wait_edges(2);
        reset = 1'b0;
        for (int i = 0; i < n_rows && !timed_out; i++) begin
            sw = {tbl_mode[i], tbl_sw[i]};
            wait_edges(tbl_edges[i]);
            if (!timed_out) check_row(i);
        end
        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0 && !timed_out && checks > 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* src/alu4.sv */
`timescale 1ns/1ps

module alu4 (
    input  lab_pkg::nib_t    a,
    input  lab_pkg::nib_t    b,
    input  lab_pkg::alu_op_t op,
    output lab_pkg::nib_t    res,
    output logic             zero,
    output logic             ovfl,
    output logic             carry
);

    logic [4:0] add_sum;
    logic [4:0] sub_sum;
    logic       add_ovfl;
    logic       sub_ovfl;

    assign add_sum = {1'b0, a} + {1'b0, b};
    // a + ~b + 1, carry out means no borrow
    assign sub_sum = {1'b0, a} + {1'b0, ~b} + 5'd1;

    assign add_ovfl = (a[3] == b[3]) && (add_sum[3] != a[3]);
    assign sub_ovfl = (a[3] != b[3]) && (sub_sum[3] != a[3]);

    always_comb begin
        res   = 4'h0;
        ovfl  = 1'b0;
        carry = 1'b0;
        case (op)
            lab_pkg::OP_ADD: begin
                res   = add_sum[3:0];
                ovfl  = add_ovfl;
                carry = add_sum[4];
            end
            lab_pkg::OP_SUB: begin
                res   = sub_sum[3:0];
                ovfl  = sub_ovfl;
                carry = sub_sum[4];
            end
            lab_pkg::OP_NOT: begin
                res = ~a;
            end
            lab_pkg::OP_AND: begin
                res = a & b;
            end
            lab_pkg::OP_OR: begin
                res = a | b;
            end
            lab_pkg::OP_XOR: begin
                res = a ^ b;
            end
            lab_pkg::OP_SLT: begin
                // sign of difference corrected by overflow
                res = {3'b000, sub_sum[3] ^ sub_ovfl};
            end
            lab_pkg::OP_EQ: begin
                res = {3'b000, a == b};
            end
            default: begin
                res = 4'h0;
            end
        endcase
    end

    assign zero = (res == 4'h0);

endmodule

/* src/barrel_shifter.sv */
`timescale 1ns/1ps

module barrel_shifter (
    input  lab_pkg::byte_t  din,
    input  lab_pkg::shamt_t shamt,
    input  logic            left,
    input  logic            arith,
    output lab_pkg::byte_t  dout
);

    logic           fill;
    lab_pkg::byte_t stage1;
    lab_pkg::byte_t stage2;
    lab_pkg::byte_t stage4;

    // sign bit only for arithmetic right shifts
    assign fill = arith & din[7];

    // by 1
    always_comb begin
        if (!shamt[0]) begin
            stage1 = din;
        end else if (left) begin
            stage1 = {din[6:0], 1'b0};
        end else begin
            stage1 = {fill, din[7:1]};
        end
    end

    // by 2
    always_comb begin
        if (!shamt[1]) begin
            stage2 = stage1;
        end else if (left) begin
            stage2 = {stage1[5:0], 2'b00};
        end else begin
            stage2 = {{2{fill}}, stage1[7:2]};
        end
    end

    // by 4
    always_comb begin
        if (!shamt[2]) begin
            stage4 = stage2;
        end else if (left) begin
            stage4 = {stage2[3:0], 4'b0000};
        end else begin
            stage4 = {{4{fill}}, stage2[7:4]};
        end
    end

    assign dout = stage4;

endmodule

/* src/hex_seg.sv */
`timescale 1ns/1ps

module hex_seg (
    input  lab_pkg::nib_t num,
    output logic [7:0]    seg
);

    // bit 0 is segment a, bit 6 is g, bit 7 the dot
    always_comb begin
        case (num)
            4'h0:    seg = 8'hC0;
            4'h1:    seg = 8'hF9;
            4'h2:    seg = 8'hA4;
            4'h3:    seg = 8'hB0;
            4'h4:    seg = 8'h99;
            4'h5:    seg = 8'h92;
            4'h6:    seg = 8'h82;
            4'h7:    seg = 8'hF8;
            4'h8:    seg = 8'h80;
            4'h9:    seg = 8'h90;
            4'hA:    seg = 8'h88;
            4'hB:    seg = 8'h83;
            4'hC:    seg = 8'hC6;
            4'hD:    seg = 8'hA1;
            4'hE:    seg = 8'h86;
            4'hF:    seg = 8'h8E;
            default: seg = lab_pkg::SEG_BLANK;
        endcase
    end

endmodule

/* src/lab_pkg.sv */
package lab_pkg;

    // widths with a meaning
    typedef logic [7:0] byte_t;
    typedef logic [3:0] nib_t;
    typedef logic [2:0] shamt_t;
    typedef logic [2:0] alu_op_t;

    // alu operation codes, from sw[10:8]
    localparam alu_op_t OP_ADD = 3'd0;
    localparam alu_op_t OP_SUB = 3'd1;
    localparam alu_op_t OP_NOT = 3'd2;
    localparam alu_op_t OP_AND = 3'd3;
    localparam alu_op_t OP_OR  = 3'd4;
    localparam alu_op_t OP_XOR = 3'd5;
    localparam alu_op_t OP_SLT = 3'd6;
    localparam alu_op_t OP_EQ  = 3'd7;

    // display source, from sw[15:14]
    typedef enum logic [1:0] {
        MODE_RAND  = 2'd0,
        MODE_SHIFT = 2'd1,
        MODE_ALU   = 2'd2,
        MODE_OFF   = 2'd3
    } mode_t;

    // all segments dark, active low
    localparam logic [7:0] SEG_BLANK = 8'hFF;

endpackage

/* src/lab_top.sv */
`timescale 1ns/1ps

module lab_top #(
    parameter lab_pkg::byte_t SEED = 8'h01
) (
    input  logic        btn,
    input  logic        reset,
    input  logic [15:0] sw,
    output logic [15:0] ledr,
    output logic [7:0]  seg0,
    output logic [7:0]  seg1,
    output logic [7:0]  seg2,
    output logic [7:0]  seg3
);

    lab_pkg::byte_t rand_val;
    lab_pkg::byte_t shift_val;
    lab_pkg::nib_t  alu_res;
    logic           alu_zero;
    logic           alu_ovfl;
    logic           alu_carry;

    // random byte, stepped by the button
    lfsr_gen #(
        .SEED (SEED)
    ) u_lfsr (
        .btn   (btn),
        .reset (reset),
        .step  (sw[13]),
        .value (rand_val)
    );

    barrel_shifter u_shift (
        .din   (sw[7:0]),
        .shamt (sw[10:8]),
        .left  (sw[11]),
        .arith (sw[12]),
        .dout  (shift_val)
    );

    // sw[10:8] doubles as the op code
    alu4 u_alu (
        .a     (sw[3:0]),
        .b     (sw[7:4]),
        .op    (sw[10:8]),
        .res   (alu_res),
        .zero  (alu_zero),
        .ovfl  (alu_ovfl),
        .carry (alu_carry)
    );

    result_display u_disp (
        .mode      (lab_pkg::mode_t'(sw[15:14])),
        .rand_val  (rand_val),
        .shift_val (shift_val),
        .alu_res   (alu_res),
        .alu_zero  (alu_zero),
        .alu_ovfl  (alu_ovfl),
        .alu_carry (alu_carry),
        .ledr      (ledr),
        .seg0      (seg0),
        .seg1      (seg1),
        .seg2      (seg2),
        .seg3      (seg3)
    );

endmodule

/* src/lfsr_gen.sv */
`timescale 1ns/1ps

module lfsr_gen #(
    parameter lab_pkg::byte_t SEED = 8'h01
) (
    input  logic           btn,
    input  logic           reset,
    input  logic           step,
    output lab_pkg::byte_t value
);

    logic           feedback;
    lab_pkg::byte_t next_value;

    // taps at 4, 3, 2 and 0 feed the top bit
    assign feedback = value[4] ^ value[3] ^ value[2] ^ value[0];

    always_comb begin
        if (value == 8'h00) begin
            // stuck state, kick back to 1
            next_value = 8'h01;
        end else begin
            next_value = {feedback, value[7:1]};
        end
    end

    always_ff @(posedge btn) begin
        if (reset) begin
            value <= SEED;
        end else if (step) begin
            value <= next_value;
        end
    end

endmodule

/* src/result_display.sv */
`timescale 1ns/1ps

module result_display (
    input  lab_pkg::mode_t mode,
    input  lab_pkg::byte_t rand_val,
    input  lab_pkg::byte_t shift_val,
    input  lab_pkg::nib_t  alu_res,
    input  logic           alu_zero,
    input  logic           alu_ovfl,
    input  logic           alu_carry,
    output logic [15:0]    ledr,
    output logic [7:0]     seg0,
    output logic [7:0]     seg1,
    output logic [7:0]     seg2,
    output logic [7:0]     seg3
);

    lab_pkg::byte_t result;
    lab_pkg::nib_t  mode_num;
    logic [7:0]     lo_pat;
    logic [7:0]     hi_pat;
    logic [7:0]     mode_pat;
    logic           dark;

    always_comb begin
        case (mode)
            lab_pkg::MODE_RAND:  result = rand_val;
            lab_pkg::MODE_SHIFT: result = shift_val;
            lab_pkg::MODE_ALU:   result = {1'b0, alu_carry, alu_ovfl, alu_zero, alu_res};
            default:             result = 8'h00;
        endcase
    end

    assign ledr     = {8'h00, result};
    assign mode_num = {2'b00, mode};
    assign dark     = (mode == lab_pkg::MODE_OFF);

    hex_seg u_hex_lo (
        .num (result[3:0]),
        .seg (lo_pat)
    );

    hex_seg u_hex_hi (
        .num (result[7:4]),
        .seg (hi_pat)
    );

    hex_seg u_hex_mode (
        .num (mode_num),
        .seg (mode_pat)
    );

    // whole display dark when off
    assign seg0 = dark ? lab_pkg::SEG_BLANK : lo_pat;
    assign seg1 = dark ? lab_pkg::SEG_BLANK : hi_pat;
    assign seg2 = dark ? lab_pkg::SEG_BLANK : mode_pat;
    assign seg3 = lab_pkg::SEG_BLANK;

endmodule
